// ==== cache2.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/line_if.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
dv/cache_assert.sv
dv/cache_checker.sv
dv/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the cache testbench with verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module cache_tb \
        -Mdir obj_dir -o sim_cache -f cache2.f \
        && ./obj_dir/sim_cache 2>&1 | tee sim.log \
        && ! grep -qF '*** FAILED ***' sim.log \
        && echo "run_sim: simulation passed" \
        && exit 0 \
        || { echo "run_sim: simulation failed"; exit 1; }

// ==== dv/cache_patterns.txt ====
// op _ address _ write data _ expected hit (1 hit, 0 miss)
// op 0 word read, 1 byte read, 2 word write, f end of list
0_00000104_00000000_0
1_00000107_00000000_1
2_00000108_11223344_1
0_00000108_00000000_1
0_00000124_00000000_0
1_00000109_00000000_1
2_0000014c_cafef00d_0
0_0000014c_00000000_1
0_00000120_00000000_0
0_00000108_00000000_0
1_0000010a_00000000_1
2_00000110_5a5a0001_0
2_0000013c_0badbeef_0
0_00000110_00000000_1
2_00002040_12345678_0
0_00002040_00000000_1
1_00002043_00000000_1
0_00000130_00000000_1
0_00000150_00000000_0
0_00000110_00000000_0
0_00000104_00000000_1
0_00000124_00000000_0
0_00002040_00000000_0
0_0000013c_00000000_0
f_00000000_00000000_0

// ==== dv/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_tb;
        import cache_pkg::*;

        localparam int MAX_OPS = 64;
        localparam int TIMEOUT = 200;           // cycles to wait for done_cpu

        logic        clk;
        logic        reset;
        logic        read_cpu;
        logic        write_cpu;
        logic        bytesel;
        logic        exp_hit;
        word_t       addr_cpu;
        word_t       data_cpu_write;
        word_t       data_cpu_read;
        word_t       addr_mem;
        logic        stall_pc;
        logic        done_cpu;
        logic        read_mem;
        logic        write_mem;
        logic        ready_mem = 1'b1;
        logic        mem_busy = 1'b0;
        logic        mem_is_read = 1'b0;
        int          mem_wait = 0;
        line_t       data_mem_read = '0;
        line_t       data_mem_write;
        logic [31:0] lfsr = 32'h816691d9;
        word_t       mem [word_t];             // backing memory, only words written back
        logic [71:0] patterns [MAX_OPS];        // op, address, write data, hit flag
        int          error_count;
        int          check_count;
        int          timeouts;
        int          op_count;

        cache_top i_dut (
                .clk            (clk),
                .reset          (reset),
                .read_cpu       (read_cpu),
                .write_cpu      (write_cpu),
                .bytesel        (bytesel),
                .addr_cpu       (addr_cpu),
                .data_cpu_write (data_cpu_write),
                .data_cpu_read  (data_cpu_read),
                .stall_pc       (stall_pc),
                .done_cpu       (done_cpu),
                .ready_mem      (ready_mem),
                .data_mem_read  (data_mem_read),
                .data_mem_write (data_mem_write),
                .addr_mem       (addr_mem),
                .read_mem       (read_mem),
                .write_mem      (write_mem)
        );

        cache_checker i_checker (
                .clk            (clk),
                .reset          (reset),
                .read_cpu       (read_cpu),
                .write_cpu      (write_cpu),
                .bytesel        (bytesel),
                .exp_hit        (exp_hit),
                .addr_cpu       (addr_cpu),
                .data_cpu_write (data_cpu_write),
                .data_cpu_read  (data_cpu_read),
                .stall_pc       (stall_pc),
                .done_cpu       (done_cpu),
                .read_mem       (read_mem),
                .write_mem      (write_mem),
                .addr_mem       (addr_mem),
                .data_mem_write (data_mem_write),
                .error_count    (error_count),
                .check_count    (check_count)
        );

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h80200003;
                return s >> 1;
        endfunction

        task automatic pick_latency(output int cycles);
                logic [1:0] b;
                for (int i = 0; i < 2; i++)
                begin
                        b[i] = lfsr[0];
                        lfsr = lfsr_next(lfsr);
                end
                cycles = 1 + int'(b);
        endtask

        function automatic word_t mem_word(input word_t a);
                if (mem.exists(a))
                        return mem[a];
                return ~a;                      // initial content, inverse of the byte address
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // memory model, one access at a time
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk)
        begin
                if (reset)
                begin
                        mem_busy  = 1'b0;
                        ready_mem = 1'b1;
                end
                else if (mem_busy)
                begin
                        if (mem_wait > 1)
                                mem_wait--;
                        else
                        begin
                                if (mem_is_read)
                                        for (int i = 0; i < `WORDS_PER_LINE; i++)
                                                data_mem_read[i] = mem_word(addr_mem + 4 * i);
                                mem_busy  = 1'b0;
                                ready_mem = 1'b1;
                        end
                end
                else if (read_mem || write_mem)
                begin
                        if (write_mem)
                                for (int i = 0; i < `WORDS_PER_LINE; i++)
                                        mem[addr_mem + 4 * i] = data_mem_write[i];
                        mem_is_read = read_mem;
                        pick_latency(mem_wait);
                        mem_busy  = 1'b1;
                        ready_mem = 1'b0;
                end
        end

        // one cpu operation, held until done_cpu and one cycle beyond
        task automatic run_op(input logic [71:0] p);
                cpu_op_t op;
                int      waited;
                logic    seen;
                op     = cpu_op_t'(p[69:68]);
                waited = 0;
                seen   = 1'b0;
                @(negedge clk);
                read_cpu       = (op != op_write_word);
                write_cpu      = (op == op_write_word);
                bytesel        = (op == op_read_byte);
                addr_cpu       = p[67:36];
                data_cpu_write = p[35:4];
                exp_hit        = p[0];
                while (!seen && waited < TIMEOUT)
                begin
                        @(negedge clk);
                        seen = done_cpu;
                        waited++;
                end
                if (!seen)
                begin
                        $display("timeout: no done_cpu for operation %0d at address %h",
                                 op_count, p[67:36]);
                        timeouts++;
                end
                @(negedge clk);
                read_cpu  = 1'b0;
                write_cpu = 1'b0;
        endtask

        initial
        begin
                reset          = 1'b1;
                read_cpu       = 1'b0;
                write_cpu      = 1'b0;
                bytesel        = 1'b0;
                addr_cpu       = '0;
                data_cpu_write = '0;
                exp_hit        = 1'b0;
                timeouts       = 0;
                op_count       = 0;
                for (int i = 0; i < MAX_OPS; i++)
                        patterns[i] = '1;       // unused entries read as the end marker
                $readmemh("dv/cache_patterns.txt", patterns);
                repeat (5) @(negedge clk);
                reset = 1'b0;
                repeat (3) @(negedge clk);      // idle, outputs must stay low
                while (op_count < MAX_OPS && patterns[op_count][71:68] != 4'hf && timeouts == 0)
                begin
                        run_op(patterns[op_count]);
                        op_count++;
                end
                repeat (2) @(negedge clk);
                $display("ops %0d, checks %0d, errors %0d, timeouts %0d",
                         op_count, check_count, error_count, timeouts);
                if (error_count == 0 && timeouts == 0 && op_count > 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        end

endmodule

// ==== dv/cache_checker.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_checker (
        input  logic             clk,
        input  logic             reset,
        input  logic             read_cpu,
        input  logic             write_cpu,
        input  logic             bytesel,
        input  logic             exp_hit,
        input  cache_pkg::word_t addr_cpu,
        input  cache_pkg::word_t data_cpu_write,
        input  cache_pkg::word_t data_cpu_read,
        input  logic             stall_pc,
        input  logic             done_cpu,
        input  logic             read_mem,
        input  logic             write_mem,
        input  cache_pkg::word_t addr_mem,
        input  cache_pkg::line_t data_mem_write,
        output int               error_count,
        output int               check_count
);
        import cache_pkg::*;

        word_t ref_mem [word_t];        // cpu-written words by word address
        bit    written [word_t];        // line addresses the cpu has written
        logic  busy;
        logic  first_seen;
        logic  miss_seen;               // read_mem pulse since the request came
        logic  req_write;
        logic  req_byte;
        logic  req_hit;
        word_t req_addr;
        word_t req_data;

        // untouched memory holds the inverse of each word's byte address
        function automatic word_t ref_word(input word_t addr);
                word_t a;
                a = {addr[`WORD_W-1:2], 2'b00};
                if (ref_mem.exists(a))
                        return ref_mem[a];
                return ~a;
        endfunction

        function automatic word_t expect_read(input word_t addr, input logic rd_byte);
                word_t w;
                w = ref_word(addr);
                if (rd_byte)
                        return (w >> {addr[1:0], 3'b000}) & 32'hff;    // zero-extended byte
                return w;
        endfunction

        task automatic compare_value(input string name, input word_t got, input word_t exp);
                check_count++;
                if (got !== exp)
                begin
                        error_count++;
                        $display("mismatch %s: got %h expected %h", name, got, exp);
                end
        endtask

        task automatic note_failure(input string msg);
                error_count++;
                $display("error: %s", msg);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // write-back blocks and finished operations
        ////////////////////////////////////////////////////////////////////////////

        task automatic check_writeback();
                word_t line_addr;
                line_addr = {addr_mem[`WORD_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
                if (line_addr !== addr_mem)
                        note_failure("write-back address is not aligned to a line");
                if (!written.exists(line_addr))
                        note_failure("write-back of a line that the cpu never wrote");
                for (int i = 0; i < `WORDS_PER_LINE; i++)
                        compare_value("data_mem_write", data_mem_write[i],
                                      ref_word(line_addr + 4 * i));
        endtask

        task automatic finish_op();
                compare_value("hit flag", word_t'(!miss_seen), word_t'(req_hit));
                if (req_write)
                begin
                        ref_mem[{req_addr[`WORD_W-1:2], 2'b00}] = req_data;
                        written[{req_addr[`WORD_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}}] = 1'b1;
                end
                else
                        compare_value("data_cpu_read", data_cpu_read,
                                      expect_read(req_addr, req_byte));
        endtask

        always @(posedge clk)
        begin
                if (reset)
                begin
                        error_count = 0;
                        check_count = 0;
                        busy        = 1'b0;
                        first_seen  = 1'b0;
                        miss_seen   = 1'b0;
                end
                else
                begin
                        if (!first_seen && (stall_pc || done_cpu || read_mem || write_mem))
                                note_failure("handshake output high before the first request");
                        // stall from the cycle after acceptance up to the done cycle
                        if (first_seen)
                                compare_value("stall_pc", word_t'(stall_pc),
                                              word_t'(busy && !done_cpu));
                        if (read_mem)
                                miss_seen = 1'b1;
                        if (write_mem)
                                check_writeback();
                        if (done_cpu && busy)
                        begin
                                finish_op();
                                busy = 1'b0;
                        end
                        else if (!busy && (read_cpu || write_cpu))
                        begin
                                req_write  = write_cpu;
                                req_byte   = read_cpu && bytesel;
                                req_hit    = exp_hit;
                                req_addr   = addr_cpu;
                                req_data   = data_cpu_write;
                                miss_seen  = 1'b0;
                                first_seen = 1'b1;
                                busy       = 1'b1;
                        end
                end
        end

endmodule

// ==== dv/cache_assert.sv ====
`timescale 1ns/100ps

module cache_assert (
        input logic clk,
        input logic reset,
        input logic read_cpu,
        input logic write_cpu,
        input logic done_cpu,
        input logic ready_mem,
        input logic read_mem,
        input logic write_mem
);

        // one memory access at a time
        mem_exclusive: assert property (@(posedge clk) disable iff (reset)
                                        !(read_mem && write_mem))
                else $error("read_mem and write_mem high in the same cycle");

        // the pulse was launched on an edge where ready_mem was high
        mem_pulse_ready: assert property (@(posedge clk) disable iff (reset)
                                          (read_mem || write_mem) |-> $past(ready_mem))
                else $error("memory pulse issued while ready_mem was low");

        done_with_request: assert property (@(posedge clk) disable iff (reset)
                                            done_cpu |-> (read_cpu || write_cpu))
                else $error("done_cpu without a held cpu request");

endmodule

bind cache_top cache_assert i_assert (
        .clk       (clk),
        .reset     (reset),
        .read_cpu  (read_cpu),
        .write_cpu (write_cpu),
        .done_cpu  (done_cpu),
        .ready_mem (ready_mem),
        .read_mem  (read_mem),
        .write_mem (write_mem)
);

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
        input  logic             clk,
        input  logic             reset,
        input  logic             read_cpu,
        input  logic             write_cpu,
        input  logic             bytesel,
        input  cache_pkg::word_t addr_cpu,
        input  cache_pkg::word_t data_cpu_write,
        output cache_pkg::word_t data_cpu_read,
        output logic             stall_pc,
        output logic             done_cpu,
        input  logic             ready_mem,
        input  cache_pkg::line_t data_mem_read,
        output cache_pkg::line_t data_mem_write,
        output cache_pkg::word_t addr_mem,
        output logic             read_mem,
        output logic             write_mem
);

        line_if lines ();       // controller to line store

        cache_ctrl i_ctrl (
                .clk            (clk),
                .reset          (reset),
                .read_cpu       (read_cpu),
                .write_cpu      (write_cpu),
                .bytesel        (bytesel),
                .addr_cpu       (addr_cpu),
                .data_cpu_write (data_cpu_write),
                .data_cpu_read  (data_cpu_read),
                .stall_pc       (stall_pc),
                .done_cpu       (done_cpu),
                .ready_mem      (ready_mem),
                .data_mem_read  (data_mem_read),
                .data_mem_write (data_mem_write),
                .addr_mem       (addr_mem),
                .read_mem       (read_mem),
                .write_mem      (write_mem),
                .lines          (lines.ctrl)
        );

        cache_store i_store (
                .clk   (clk),
                .reset (reset),
                .lines (lines.store)
        );

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_ctrl (
        input  logic             clk,
        input  logic             reset,
        input  logic             read_cpu,
        input  logic             write_cpu,
        input  logic             bytesel,
        input  cache_pkg::word_t addr_cpu,
        input  cache_pkg::word_t data_cpu_write,
        output cache_pkg::word_t data_cpu_read,
        output logic             stall_pc,
        output logic             done_cpu,
        input  logic             ready_mem,
        input  cache_pkg::line_t data_mem_read,
        output cache_pkg::line_t data_mem_write,
        output cache_pkg::word_t addr_mem,
        output logic             read_mem,
        output logic             write_mem,
        line_if.ctrl             lines
);
        import cache_pkg::*;

        ctrl_state_t state;
        cpu_op_t     req_op;
        word_t       req_addr;
        word_t       req_data;
        logic        accept;
        logic        fill_done;
        logic [7:0]  hit_byte;

        // no new request in the cycle of done_cpu
        assign accept = (state == st_idle) && !done_cpu && (read_cpu || write_cpu);

        // read_mem still high means memory has not taken the pulse yet
        assign fill_done = (state == st_fill_wait) && ready_mem && !read_mem;

        assign hit_byte = lines.hit_word[req_addr[1:0]*8 +: 8];

        ////////////////////////////////////////////////////////////////////////////
        // requests to the line store
        ////////////////////////////////////////////////////////////////////////////

        assign lines.index     = req_addr[`OFFSET_W +: `INDEX_W];
        assign lines.tag       = req_addr[`WORD_W-1 -: `TAG_W];
        assign lines.word_sel  = req_addr[`OFFSET_W-1:2];
        assign lines.wr_word   = req_data;
        assign lines.fill_line = data_mem_read;
        assign lines.word_wr   = (state == st_lookup) && lines.hit && (req_op == op_write_word);
        assign lines.fill      = fill_done;
        assign lines.touch     = ((state == st_lookup) && lines.hit) || fill_done;
        assign lines.way       = fill_done ? lines.victim_way : lines.hit_way;

        ////////////////////////////////////////////////////////////////////////////
        // state machine and handshake outputs
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state     <= st_idle;
                        stall_pc  <= 1'b0;
                        done_cpu  <= 1'b0;
                        read_mem  <= 1'b0;
                        write_mem <= 1'b0;
                end
                else
                begin
                        done_cpu  <= 1'b0;      // all three are single-cycle pulses
                        read_mem  <= 1'b0;
                        write_mem <= 1'b0;
                        case (state)
                                st_idle:
                                begin
                                        if (accept)
                                        begin
                                                stall_pc <= 1'b1;
                                                state    <= st_lookup;
                                        end
                                end
                                st_lookup:
                                begin
                                        if (lines.hit)
                                        begin
                                                done_cpu <= 1'b1;
                                                stall_pc <= 1'b0;
                                                state    <= st_idle;
                                        end
                                        else if (lines.victim_valid && lines.victim_dirty)
                                                state <= st_evict;
                                        else
                                                state <= st_fill;
                                end
                                st_evict:
                                begin
                                        if (ready_mem)
                                        begin
                                                write_mem <= 1'b1;
                                                state     <= st_evict_wait;
                                        end
                                end
                                st_evict_wait:
                                begin
                                        if (ready_mem && !write_mem)
                                                state <= st_fill;
                                end
                                st_fill:
                                begin
                                        if (ready_mem)
                                        begin
                                                read_mem <= 1'b1;
                                                state    <= st_fill_wait;
                                        end
                                end
                                st_fill_wait:
                                begin
                                        // back to lookup, which now hits and finishes the op
                                        if (fill_done)
                                                state <= st_lookup;
                                end
                                default:
                                        state <= st_idle;
                        endcase
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // request latch and data paths
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (accept)
                begin
                        req_addr <= addr_cpu;
                        req_data <= data_cpu_write;
                        if (read_cpu)
                                req_op <= bytesel ? op_read_byte : op_read_word;
                        else
                                req_op <= op_write_word;
                end
                if ((state == st_lookup) && lines.hit)
                        data_cpu_read <= (req_op == op_read_byte) ?
                                         {{(`WORD_W-8){1'b0}}, hit_byte} : lines.hit_word;
                if ((state == st_evict) && ready_mem)
                begin
                        // victim address rebuilt from its stored tag
                        addr_mem       <= {lines.victim_tag, lines.index, {`OFFSET_W{1'b0}}};
                        data_mem_write <= lines.victim_line;    // held until ready_mem rises
                end
                if ((state == st_fill) && ready_mem)
                        addr_mem <= {req_addr[`WORD_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
        end

endmodule

// ==== rtl/cache_store.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_store (
        input logic   clk,
        input logic   reset,
        line_if.store lines
);
        import cache_pkg::*;

        localparam int NUM_WAYS = 2;

        line_t                data_arr [NUM_WAYS][`NUM_SETS];
        tag_t                 tag_arr  [NUM_WAYS][`NUM_SETS];
        logic [`NUM_SETS-1:0] valid    [NUM_WAYS];
        logic [`NUM_SETS-1:0] dirty    [NUM_WAYS];
        logic [`NUM_SETS-1:0] lru;              // per set, the way to replace next
        logic [NUM_WAYS-1:0]  way_hit;
        logic                 hway;
        logic                 vway;

        ////////////////////////////////////////////////////////////////////////////
        // lookup, purely combinational
        ////////////////////////////////////////////////////////////////////////////

        always_comb
        begin
                for (int w = 0; w < NUM_WAYS; w++)
                        way_hit[w] = valid[w][lines.index] &&
                                     (tag_arr[w][lines.index] == lines.tag);
        end

        assign hway = way_hit[1];

        // an empty way wins over the lru way
        always_comb
        begin
                if (!valid[0][lines.index])
                        vway = 1'b0;
                else if (!valid[1][lines.index])
                        vway = 1'b1;
                else
                        vway = lru[lines.index];
        end

        assign lines.hit          = |way_hit;
        assign lines.hit_way      = hway;
        assign lines.hit_word     = data_arr[hway][lines.index][lines.word_sel];
        assign lines.victim_way   = vway;
        assign lines.victim_valid = valid[vway][lines.index];
        assign lines.victim_dirty = dirty[vway][lines.index];
        assign lines.victim_tag   = tag_arr[vway][lines.index];
        assign lines.victim_line  = data_arr[vway][lines.index];

        ////////////////////////////////////////////////////////////////////////////
        // updates on the clock edge
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        for (int w = 0; w < NUM_WAYS; w++)
                        begin
                                valid[w] <= '0;
                                dirty[w] <= '0;
                        end
                        lru <= '0;
                end
                else
                begin
                        if (lines.fill)
                        begin
                                valid[lines.way][lines.index] <= 1'b1;
                                dirty[lines.way][lines.index] <= 1'b0;  // fresh line is clean
                        end
                        else if (lines.word_wr)
                                dirty[lines.way][lines.index] <= 1'b1;
                        if (lines.touch)
                                lru[lines.index] <= ~lines.way;         // other way is now lru
                end
        end

        always_ff @(posedge clk)
        begin
                if (lines.fill)
                begin
                        data_arr[lines.way][lines.index] <= lines.fill_line;
                        tag_arr[lines.way][lines.index]  <= lines.tag;
                end
                else if (lines.word_wr)
                        data_arr[lines.way][lines.index][lines.word_sel] <= lines.wr_word;
        end

endmodule

// ==== rtl/line_if.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

interface line_if;
        import cache_pkg::*;

        localparam int WSEL_W = $clog2(`WORDS_PER_LINE);

        // controller to store
        logic [`INDEX_W-1:0] index;
        tag_t                tag;               // lookup tag, also the tag written on fill
        logic [WSEL_W-1:0]   word_sel;
        word_t               wr_word;
        line_t               fill_line;
        logic                word_wr;
        logic                fill;
        logic                touch;
        logic                way;               // way that word_wr, fill and touch act on

        // store to controller
        logic  hit;
        logic  hit_way;
        logic  victim_way;
        logic  victim_valid;
        logic  victim_dirty;
        tag_t  victim_tag;
        line_t victim_line;
        word_t hit_word;

        modport ctrl (output index, tag, word_sel, wr_word, fill_line, word_wr, fill, touch, way,
                      input hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
                            victim_line, hit_word);

        modport store (input index, tag, word_sel, wr_word, fill_line, word_wr, fill, touch, way,
                       output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
                              victim_line, hit_word);

endinterface

// ==== rtl/cache_pkg.sv ====
`include "cache_defines.svh"

package cache_pkg;

        typedef logic [`WORD_W-1:0] word_t;
        typedef logic [`TAG_W-1:0]  tag_t;

        // word 0 sits in the low bits of the line
        typedef logic [`LINE_W/`WORD_W-1:0][`WORD_W-1:0] line_t;

        // request kind, same codes as the pattern file
        typedef enum logic [1:0] {
                op_read_word  = 2'd0,
                op_read_byte  = 2'd1,
                op_write_word = 2'd2
        } cpu_op_t;

        typedef enum logic [2:0] {
                st_idle       = 3'd0,
                st_lookup     = 3'd1,
                st_evict      = 3'd2,   // write-back pulse
                st_evict_wait = 3'd3,
                st_fill       = 3'd4,   // line read pulse
                st_fill_wait  = 3'd5
        } ctrl_state_t;

endpackage

// ==== rtl/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu word and line geometry
`define WORD_W          32
`define WORDS_PER_LINE  4
`define LINE_W          128

// two sets, index is address bit 4
`define NUM_SETS        2
`define INDEX_W         1

`define OFFSET_W        4       // byte offset inside a line
`define TAG_W           27      // address bits 31 to 5

`endif
